/* sim.f */
design/cache_pkg.sv
design/axi_pkg.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/axi_reg_slice.sv
design/icache_ctrl.sv
design/icache_top.sv
verif/icache_props.sv
verif/icache_tb.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f sim.f --top-module icache_tb -o icache_sim \
	&& ./obj_dir/icache_sim +verilator+error+limit+1000 \
	| tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* verif/icache_tb.sv */
`timescale 1ns/1ns

module icache_tb;
	import cache_pkg::*;
	import axi_pkg::*;

	localparam logic [31:0] SEED = 32'd3693;
	localparam logic [31:0] DATA_KEY = 32'h5EED_0000;
	// upper bound on requests at about 40 cycles each
	localparam int NUM_REQ = 220;
	localparam int CYCLE_LIMIT = 40 * NUM_REQ;

	logic clk;
	logic rst;
	ar_lite_t fetch_ar;
	logic fetch_arvalid;
	logic fetch_arready;
	r_lite_t fetch_r;
	logic fetch_rvalid;
	logic fetch_rready;
	ar_burst_t mem_ar;
	logic mem_arvalid;
	logic mem_arready;
	r_burst_t mem_r;
	logic mem_rvalid;
	logic mem_rready;
	logic fence_i;

	int errors = 0;
	int n_requests = 0;
	// bursts accepted by the memory model
	int ar_count = 0;
	// address of the fetch in progress
	logic [31:0] cur_addr = '0;
	logic [31:0] fetch_rng = SEED;
	logic [31:0] mem_rng = SEED;

	// reference copy of the tag store
	logic [NUM_LINES-1:0] model_valid;
	logic [TAG_W-1:0] model_tag [NUM_LINES];

	icache_top dut (.*);

	initial begin : clock_gen
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		assert (actual === expected) else begin
			errors++;
			$display("Error: %0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	// ------------------------------------------------------------------
	// memory model with 4 beats per burst and random stalls
	// ------------------------------------------------------------------

	initial begin : memory_model
		logic [31:0] base;
		logic [31:0] rnd;
		logic busy;
		logic taken;
		int beat;
		base = '0;
		busy = 1'b0;
		taken = 1'b0;
		beat = 0;
		mem_arready = 1'b0;
		mem_rvalid = 1'b0;
		mem_r = '0;
		mem_rng = xorshift32(SEED);
		// everything moves on the falling edge so transfers land on the next rising edge
		forever begin
			@(negedge clk);
			// beat handed over at the last rising edge
			if (taken) begin
				beat++;
				if (beat == 4) begin
					busy = 1'b0;
				end
			end
			mem_rng = xorshift32(mem_rng);
			rnd = mem_rng;
			mem_arready = !busy && (rnd[1:0] != 2'b00);
			// a beat on offer stays until taken
			if (!mem_rvalid || taken) begin
				mem_rvalid = busy && (rnd[3:2] != 2'b00);
				mem_r = '{data: (base + 32'(beat * 4)) ^ DATA_KEY, resp: OKAY,
					last: (beat == 3)};
			end
			taken = mem_rvalid && mem_rready;
			if (mem_arvalid && mem_arready) begin
				ar_count++;
				check_eq("mem_ar.addr", mem_ar.addr, {cur_addr[31:4], 4'h0});
				check_eq("mem_ar.len", 32'(mem_ar.len), 32'd3);
				check_eq("mem_ar.burst", 32'(mem_ar.burst), 32'(BURST_INCR));
				base = mem_ar.addr;
				beat = 0;
				busy = 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------
	// fetch model
	// ------------------------------------------------------------------

	// one fetch with an optional fence fence_at cycles after the AR transfer
	task automatic do_fetch(input logic [31:0] addr, input int fence_at);
		logic [INDEX_W-1:0] idx;
		logic [TAG_W-1:0] tag;
		logic exp_hit;
		logic done;
		logic fenced;
		logic arv_at2;
		logic [31:0] got;
		logic [1:0] got_resp;
		int lat;
		int first_lat;
		int ar_before;
		idx = addr[7:4];
		tag = addr[31:8];
		exp_hit = model_valid[idx] && (model_tag[idx] == tag);
		lat = 0;
		first_lat = 0;
		done = 1'b0;
		fenced = 1'b0;
		arv_at2 = 1'b0;
		got = '0;
		got_resp = '0;
		@(negedge clk);
		cur_addr = addr;
		ar_before = ar_count;
		fetch_ar = '{addr: addr, prot: 3'b100};
		fetch_arvalid = 1'b1;
		// ready seen mid-cycle means the transfer happens at the next rising edge
		while (!fetch_arready) begin
			@(negedge clk);
		end
		// lat counts cycles after the AR transfer cycle
		while (!done) begin
			@(negedge clk);
			lat++;
			fetch_arvalid = 1'b0;
			fence_i = (lat == fence_at);
			if (lat == fence_at) begin
				fenced = 1'b1;
			end
			fetch_rng = xorshift32(fetch_rng);
			fetch_rready = (fetch_rng[1:0] != 2'b00);
			if (lat == 2) begin
				arv_at2 = mem_arvalid;
			end
			if (fetch_rvalid && (first_lat == 0)) begin
				first_lat = lat;
			end
			// response taken at the coming rising edge
			if (fetch_rvalid && fetch_rready) begin
				done = 1'b1;
				got = fetch_r.data;
				got_resp = fetch_r.resp;
			end
		end
		@(negedge clk);
		fence_i = 1'b0;
		fetch_rready = 1'b0;
		check_eq("fetch_r.data", got, addr ^ DATA_KEY);
		check_eq("fetch_r.resp", 32'(got_resp), 32'(OKAY));
		if (exp_hit) begin
			check_eq("fetch_rvalid latency", first_lat, 32'd2);
			check_eq("mem_ar count on hit", ar_count - ar_before, 32'd0);
		end else begin
			check_eq("mem_arvalid 2 cycles after miss", 32'(arv_at2), 32'd1);
			check_eq("mem_ar count on miss", ar_count - ar_before, 32'd1);
			model_valid[idx] = 1'b1;
			model_tag[idx] = tag;
		end
		// the refill lands first, then the flush clears it
		if (fenced) begin
			model_valid = '0;
		end
		n_requests++;
	endtask

	// fence while the cache is idle
	task automatic pulse_fence();
		@(negedge clk);
		fence_i = 1'b1;
		@(negedge clk);
		fence_i = 1'b0;
		model_valid = '0;
	endtask

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------

	initial begin : stimulus
		logic [31:0] rnd;
		int i;
		int fence_at;
		rst = 1'b1;
		fetch_ar = '0;
		fetch_arvalid = 1'b0;
		fetch_rready = 1'b0;
		fence_i = 1'b0;
		model_valid = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// two tags per index give a mix of hits and evictions
		for (i = 0; i < 100; i++) begin
			fetch_rng = xorshift32(fetch_rng);
			rnd = fetch_rng;
			do_fetch(32'h0000_4000 + {23'd0, rnd[8:2], 2'b00}, -1);
		end
		// same index with different tags
		for (i = 0; i < 10; i++) begin
			do_fetch(32'h0000_4024, -1);
			do_fetch(32'h0000_8028, -1);
		end
		// fence between fetches
		for (i = 0; i < 8; i++) begin
			do_fetch(32'h0000_6000 + 32'(i * 16), -1);
		end
		pulse_fence();
		for (i = 0; i < 8; i++) begin
			do_fetch(32'h0000_6004 + 32'(i * 16), -1);
		end
		// fence in the middle of a refill
		for (i = 0; i < 8; i++) begin
			do_fetch(32'h0000_7000 + 32'(i * 16), -1);
		end
		do_fetch(32'h0000_7F08, 3);
		for (i = 0; i < 8; i++) begin
			do_fetch(32'h0000_7008 + 32'(i * 16), -1);
		end
		do_fetch(32'h0000_7F0C, -1);
		// four tags per index with fences at random points
		for (i = 0; i < 60; i++) begin
			fetch_rng = xorshift32(fetch_rng);
			rnd = fetch_rng;
			fence_at = (rnd[15:13] == 3'd0) ? int'(rnd[12:10]) + 1 : -1;
			if (rnd[18:16] == 3'd7) begin
				pulse_fence();
			end
			do_fetch(32'h0000_4000 + {22'd0, rnd[9:2], 2'b00}, fence_at);
		end
		repeat (4) @(negedge clk);
		$display("%0d requests, %0d check errors, %0d property failures",
			n_requests, errors, dut.u_props.fail_count);
		if ((errors == 0) && (dut.u_props.fail_count == 0)) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

/* verif/icache_props.sv */
`timescale 1ns/1ns

module icache_props (
	input logic               clk,
	input logic               rst,
	input logic               fetch_arvalid,
	input logic               fetch_arready,
	input axi_pkg::r_lite_t   fetch_r,
	input logic               fetch_rvalid,
	input logic               fetch_rready,
	input axi_pkg::ar_burst_t mem_ar,
	input logic               mem_arvalid,
	input logic               mem_arready,
	input logic               mem_rready
);
	import axi_pkg::*;

	// count of failed properties
	int fail_count = 0;
	// one fetch accepted, response not yet taken
	logic outstanding;

	always_ff @(posedge clk) begin
		if (rst) begin
			outstanding <= 1'b0;
		end else if (fetch_arvalid && fetch_arready) begin
			outstanding <= 1'b1;
		end else if (fetch_rvalid && fetch_rready) begin
			outstanding <= 1'b0;
		end
	end

	// ------------------------------------------------------------------
	// fetch side
	// ------------------------------------------------------------------

	// response held under back-pressure
	fetch_r_hold: assert property (@(posedge clk) disable iff (rst)
		fetch_rvalid && !fetch_rready |=> fetch_rvalid && $stable(fetch_r))
	else begin
		fail_count++;
		$error("fetch response dropped or changed while fetch_rready was low");
	end

	// single outstanding fetch
	fetch_one_at_a_time: assert property (@(posedge clk) disable iff (rst)
		outstanding |-> !fetch_arready)
	else begin
		fail_count++;
		$error("fetch_arready high while a fetch is outstanding");
	end

	// ------------------------------------------------------------------
	// memory side
	// ------------------------------------------------------------------

	// burst request held until taken
	mem_ar_hold: assert property (@(posedge clk) disable iff (rst)
		mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_ar))
	else begin
		fail_count++;
		$error("mem_ar dropped or changed before mem_arready");
	end

	// whole aligned line, 4 beats, incrementing
	mem_ar_shape: assert property (@(posedge clk) disable iff (rst)
		mem_arvalid |-> mem_ar.len == 8'd3 && mem_ar.burst == BURST_INCR
			&& mem_ar.addr[3:0] == 4'h0)
	else begin
		fail_count++;
		$error("mem_ar is not a line aligned 4 beat INCR burst");
	end

	// quiet outputs while in reset
	reset_quiet: assert property (@(posedge clk)
		rst |=> !fetch_rvalid && !mem_arvalid && !mem_rready && !fetch_arready)
	else begin
		fail_count++;
		$error("handshake output active during reset");
	end

endmodule

bind icache_top icache_props u_props (
	.clk(clk), .rst(rst),
	.fetch_arvalid(fetch_arvalid), .fetch_arready(fetch_arready),
	.fetch_r(fetch_r), .fetch_rvalid(fetch_rvalid), .fetch_rready(fetch_rready),
	.mem_ar(mem_ar), .mem_arvalid(mem_arvalid), .mem_arready(mem_arready),
	.mem_rready(mem_rready)
);

/* design/icache_top.sv */
`timescale 1ns/1ns

module icache_top (
	input  logic               clk,
	input  logic               rst,
	input  axi_pkg::ar_lite_t  fetch_ar,
	input  logic               fetch_arvalid,
	output logic               fetch_arready,
	output axi_pkg::r_lite_t   fetch_r,
	output logic               fetch_rvalid,
	input  logic               fetch_rready,
	output axi_pkg::ar_burst_t mem_ar,
	output logic               mem_arvalid,
	input  logic               mem_arready,
	input  axi_pkg::r_burst_t  mem_r,
	input  logic               mem_rvalid,
	output logic               mem_rready,
	input  logic               fence_i
);
	import cache_pkg::*;
	import axi_pkg::*;

	// controller to ar slice
	ar_burst_t refill_ar;
	logic refill_arvalid;
	logic refill_arready;
	// r slice to controller
	r_burst_t refill_r;
	logic refill_rvalid;
	logic refill_rready;

	// tag array wires
	logic tag_rd_en;
	logic [INDEX_W-1:0] tag_rd_index;
	logic [TAG_W-1:0] tag_rd_tag;
	logic tag_rd_valid;
	logic tag_wr_en;
	logic [INDEX_W-1:0] tag_wr_index;
	logic [TAG_W-1:0] tag_wr_tag;
	logic tag_flush;

	// data array wires
	logic data_rd_en;
	logic [INDEX_W-1:0] data_rd_index;
	logic [OFFSET_W-1:0] data_rd_offset;
	logic [31:0] data_rd_data;
	logic data_wr_en;
	logic [INDEX_W-1:0] data_wr_index;
	logic [OFFSET_W-1:0] data_wr_offset;
	logic [31:0] data_wr_data;

	// ------------------------------------------------------------------
	// controller and arrays
	// ------------------------------------------------------------------

	icache_ctrl u_ctrl (.*);

	icache_tag_array u_tag (
		.clk, .rst,
		.rd_en(tag_rd_en), .rd_index(tag_rd_index),
		.rd_tag(tag_rd_tag), .rd_valid(tag_rd_valid),
		.wr_en(tag_wr_en), .wr_index(tag_wr_index), .wr_tag(tag_wr_tag),
		.flush(tag_flush)
	);

	icache_data_array u_data (
		.clk,
		.rd_en(data_rd_en), .rd_index(data_rd_index),
		.rd_offset(data_rd_offset), .rd_data(data_rd_data),
		.wr_en(data_wr_en), .wr_index(data_wr_index),
		.wr_offset(data_wr_offset), .wr_data(data_wr_data)
	);

	// ------------------------------------------------------------------
	// memory port slices
	// ------------------------------------------------------------------

	axi_reg_slice #(.payload_t(ar_burst_t)) u_ar_slice (
		.clk, .rst,
		.in_data(refill_ar), .in_valid(refill_arvalid), .in_ready(refill_arready),
		.out_data(mem_ar), .out_valid(mem_arvalid), .out_ready(mem_arready)
	);

	axi_reg_slice #(.payload_t(r_burst_t)) u_r_slice (
		.clk, .rst,
		.in_data(mem_r), .in_valid(mem_rvalid), .in_ready(mem_rready),
		.out_data(refill_r), .out_valid(refill_rvalid), .out_ready(refill_rready)
	);

endmodule

/* design/icache_ctrl.sv */
`timescale 1ns/1ns

module icache_ctrl (
	input  logic                          clk,
	input  logic                          rst,
	// fetch side
	input  axi_pkg::ar_lite_t             fetch_ar,
	input  logic                          fetch_arvalid,
	output logic                          fetch_arready,
	output axi_pkg::r_lite_t              fetch_r,
	output logic                          fetch_rvalid,
	input  logic                          fetch_rready,
	input  logic                          fence_i,
	// refill side
	output axi_pkg::ar_burst_t            refill_ar,
	output logic                          refill_arvalid,
	input  logic                          refill_arready,
	input  axi_pkg::r_burst_t             refill_r,
	input  logic                          refill_rvalid,
	output logic                          refill_rready,
	// tag array
	output logic                          tag_rd_en,
	output logic [cache_pkg::INDEX_W-1:0]  tag_rd_index,
	input  logic [cache_pkg::TAG_W-1:0]    tag_rd_tag,
	input  logic                          tag_rd_valid,
	output logic                          tag_wr_en,
	output logic [cache_pkg::INDEX_W-1:0]  tag_wr_index,
	output logic [cache_pkg::TAG_W-1:0]    tag_wr_tag,
	output logic                          tag_flush,
	// data array
	output logic                          data_rd_en,
	output logic [cache_pkg::INDEX_W-1:0]  data_rd_index,
	output logic [cache_pkg::OFFSET_W-1:0] data_rd_offset,
	input  logic [31:0]                   data_rd_data,
	output logic                          data_wr_en,
	output logic [cache_pkg::INDEX_W-1:0]  data_wr_index,
	output logic [cache_pkg::OFFSET_W-1:0] data_wr_offset,
	output logic [31:0]                   data_wr_data
);
	import cache_pkg::*;
	import axi_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;

	// request held for the whole transaction
	addr_fields_t req;
	addr_fields_t fetch_fields;
	// word handed back on the fetch r channel
	logic [31:0] rdata_q;
	logic [OFFSET_W-1:0] beat_cnt;
	// fence seen while busy
	logic fence_pending;

	logic fetch_fire;
	logic beat_fire;
	logic hit;

	assign fetch_fields = addr_fields_t'(fetch_ar.addr);

	// ------------------------------------------------------------------
	// handshakes
	// ------------------------------------------------------------------

	// blocked whenever a flush is due
	assign fetch_arready = (state == ST_IDLE) && !fence_i && !fence_pending;
	assign fetch_fire = fetch_arvalid && fetch_arready;
	assign fetch_rvalid = (state == ST_RESPOND);
	assign fetch_r = '{data: rdata_q, resp: OKAY};

	// arrays come back one cycle after the fire
	assign hit = tag_rd_valid && (tag_rd_tag == req.tag);

	// burst request goes out straight from the compare on a miss
	assign refill_arvalid = ((state == ST_LOOKUP) && !hit) || (state == ST_REFILL_ADDR);
	// whole line, starting at word 0
	assign refill_ar = '{
		addr:  {req.tag, req.index, {(OFFSET_W + BYTE_W){1'b0}}},
		len:   8'(LINE_WORDS - 1),
		burst: BURST_INCR
	};
	assign refill_rready = (state == ST_REFILL_DATA);
	assign beat_fire = refill_rvalid && refill_rready;

	// ------------------------------------------------------------------
	// array control
	// ------------------------------------------------------------------

	// both arrays read from the incoming address
	assign tag_rd_en = fetch_fire;
	assign tag_rd_index = fetch_fields.index;
	assign data_rd_en = fetch_fire;
	assign data_rd_index = fetch_fields.index;
	assign data_rd_offset = fetch_fields.offset;

	// every beat lands at the beat counter
	assign data_wr_en = beat_fire;
	assign data_wr_index = req.index;
	assign data_wr_offset = beat_cnt;
	assign data_wr_data = refill_r.data;

	// tag goes valid with the last beat
	assign tag_wr_en = beat_fire && refill_r.last;
	assign tag_wr_index = req.index;
	assign tag_wr_tag = req.tag;
	assign tag_flush = (state == ST_FLUSH);

	// ------------------------------------------------------------------
	// next state
	// ------------------------------------------------------------------

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (fence_i || fence_pending) begin
					state_next = ST_FLUSH;
				end else if (fetch_fire) begin
					state_next = ST_LOOKUP;
				end
			end
			ST_LOOKUP: begin
				if (hit) begin
					state_next = ST_RESPOND;
				end else if (refill_arready) begin
					state_next = ST_REFILL_DATA;
				end else begin
					state_next = ST_REFILL_ADDR;
				end
			end
			ST_REFILL_ADDR: begin
				if (refill_arready) begin
					state_next = ST_REFILL_DATA;
				end
			end
			ST_REFILL_DATA: begin
				if (beat_fire && refill_r.last) begin
					state_next = ST_RESPOND;
				end
			end
			ST_RESPOND: begin
				if (fetch_rready) begin
					state_next = ST_IDLE;
				end
			end
			ST_FLUSH: state_next = ST_IDLE;
			default: state_next = ST_IDLE;
		endcase
	end

	// ------------------------------------------------------------------
	// registers
	// ------------------------------------------------------------------

	// reset parks in flush, so fetch stays blocked while rst is high
	always_ff @(posedge clk) begin
		if (rst) begin
			state         <= ST_FLUSH;
			fence_pending <= 1'b0;
			beat_cnt      <= '0;
		end else begin
			state <= state_next;
			// idle always turns a pending fence into a flush
			if (state == ST_IDLE) begin
				fence_pending <= 1'b0;
			end else if (fence_i) begin
				fence_pending <= 1'b1;
			end
			if (state == ST_LOOKUP) begin
				beat_cnt <= '0;
			end else if (beat_fire) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_fire) begin
			req <= fetch_fields;
		end
		if ((state == ST_LOOKUP) && hit) begin
			rdata_q <= data_rd_data;
		end
		// keep the requested word as its beat passes
		if (beat_fire && (beat_cnt == req.offset)) begin
			rdata_q <= refill_r.data;
		end
	end

endmodule

/* design/axi_reg_slice.sv */
`timescale 1ns/1ns

module axi_reg_slice #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     rst,
	input  payload_t in_data,
	input  logic     in_valid,
	output logic     in_ready,
	output payload_t out_data,
	output logic     out_valid,
	input  logic     out_ready
);

	// set on the first cycle out of reset
	logic armed;

	// take a new item when empty or when the held one leaves this cycle
	assign in_ready = armed && (!out_valid || out_ready);

	// ------------------------------------------------------------------
	// control
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			armed     <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			armed <= 1'b1;
			if (in_ready) begin
				out_valid <= in_valid;
			end
		end
	end

	// ------------------------------------------------------------------
	// payload
	// ------------------------------------------------------------------

	// only loads on an accepted transfer
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_data <= in_data;
		end
	end

endmodule

/* design/icache_data_array.sv */
`timescale 1ns/1ns

module icache_data_array (
	input  logic                          clk,
	input  logic                          rd_en,
	input  logic [cache_pkg::INDEX_W-1:0]  rd_index,
	input  logic [cache_pkg::OFFSET_W-1:0] rd_offset,
	output logic [31:0]                   rd_data,
	input  logic                          wr_en,
	input  logic [cache_pkg::INDEX_W-1:0]  wr_index,
	input  logic [cache_pkg::OFFSET_W-1:0] wr_offset,
	input  logic [31:0]                   wr_data
);
	import cache_pkg::*;

	// ------------------------------------------------------------------
	// word storage, line by word
	// ------------------------------------------------------------------

	logic [31:0] words [NUM_LINES][LINE_WORDS];

	// refill writes one beat per transfer
	always_ff @(posedge clk) begin
		if (wr_en) begin
			words[wr_index][wr_offset] <= wr_data;
		end
	end

	// ------------------------------------------------------------------
	// read port
	// ------------------------------------------------------------------

	// one word out, registered
	// holds its value while rd_en is low
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= words[rd_index][rd_offset];
		end
	end

endmodule

/* design/icache_tag_array.sv */
`timescale 1ns/1ns

module icache_tag_array (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         rd_en,
	input  logic [cache_pkg::INDEX_W-1:0] rd_index,
	output logic [cache_pkg::TAG_W-1:0]   rd_tag,
	output logic                         rd_valid,
	input  logic                         wr_en,
	input  logic [cache_pkg::INDEX_W-1:0] wr_index,
	input  logic [cache_pkg::TAG_W-1:0]   wr_tag,
	input  logic                         flush
);
	import cache_pkg::*;

	// one tag per line
	logic [TAG_W-1:0] tags [NUM_LINES];
	// one valid bit per line, kept flat for the flash clear
	logic [NUM_LINES-1:0] valid;

	// ------------------------------------------------------------------
	// valid bits
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			valid <= '0;
		end else if (wr_en) begin
			valid[wr_index] <= 1'b1;
		end
	end

	// tag storage
	always_ff @(posedge clk) begin
		if (wr_en) begin
			tags[wr_index] <= wr_tag;
		end
	end

	// ------------------------------------------------------------------
	// registered lookup
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_valid <= 1'b0;
		end else if (rd_en) begin
			rd_valid <= valid[rd_index];
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_tag <= tags[rd_index];
		end
	end

endmodule

/* design/axi_pkg.sv */
package axi_pkg;

	// ------------------------------------------------------------------
	// codes
	// ------------------------------------------------------------------

	localparam logic [1:0] OKAY = 2'b00;
	localparam logic [1:0] BURST_INCR = 2'b01;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// ------------------------------------------------------------------
	// fetch side, axi4-lite read
	// ------------------------------------------------------------------

	// ar channel payload
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [2:0]        prot;
	} ar_lite_t;

	// r channel payload
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
	} r_lite_t;

	// ------------------------------------------------------------------
	// memory side, axi4 read burst
	// ------------------------------------------------------------------

	// len is beats minus one
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0]        len;
		logic [1:0]        burst;
	} ar_burst_t;

	// last marks the final beat
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
		logic              last;
	} r_burst_t;

endpackage

/* design/cache_pkg.sv */
package cache_pkg;

	// ------------------------------------------------------------------
	// cache geometry
	// ------------------------------------------------------------------

	// direct mapped, 16 lines
	localparam int INDEX_W = 4;
	// 4 words per line
	localparam int OFFSET_W = 2;
	// byte select inside a 32-bit word
	localparam int BYTE_W = 2;

	localparam int NUM_LINES = 1 << INDEX_W;
	localparam int LINE_WORDS = 1 << OFFSET_W;

	// whatever is left above index and offset
	localparam int TAG_W = 32 - INDEX_W - OFFSET_W - BYTE_W;

	// ------------------------------------------------------------------
	// address split, msb first
	// ------------------------------------------------------------------

	typedef struct packed {
		logic [TAG_W-1:0]    tag;
		logic [INDEX_W-1:0]  index;
		logic [OFFSET_W-1:0] offset;
		logic [BYTE_W-1:0]   byte_sel;
	} addr_fields_t;

	// ------------------------------------------------------------------
	// controller states
	// ------------------------------------------------------------------

	typedef enum logic [2:0] {
		// waiting for a fetch
		ST_IDLE        = 3'd0,
		// arrays read, compare tag
		ST_LOOKUP      = 3'd1,
		// word held on fetch r channel
		ST_RESPOND     = 3'd2,
		// burst address not yet taken
		ST_REFILL_ADDR = 3'd3,
		// collecting burst beats
		ST_REFILL_DATA = 3'd4,
		// one cycle valid clear
		ST_FLUSH       = 3'd5
	} ctrl_state_t;

endpackage
